//--- dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry

// ways per set
`define DCACHE_WAYS 2

// sets per way
`define DCACHE_SETS 128

// 32-bit words in one line
`define DCACHE_WORDS_PER_LINE 16

// bytes in one word
`define DCACHE_WORD_BYTES 4

// request and bus address width
`define DCACHE_ADDR_WIDTH 32

`endif

//--- dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    localparam int ALIGN_BITS  = $clog2(`DCACHE_WORD_BYTES);
    localparam int OFFSET_BITS = $clog2(`DCACHE_WORDS_PER_LINE);
    localparam int INDEX_BITS  = $clog2(`DCACHE_SETS);
    localparam int WAY_BITS    = $clog2(`DCACHE_WAYS);
    localparam int TAG_BITS    = `DCACHE_ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [`DCACHE_WORD_BYTES*8-1:0] word_t;
    typedef logic [`DCACHE_WORD_BYTES-1:0]   strobe_t;
    typedef logic [INDEX_BITS-1:0]           index_t;
    typedef logic [OFFSET_BITS-1:0]          offset_t;
    typedef logic [TAG_BITS-1:0]             tag_t;
    typedef logic [WAY_BITS-1:0]             way_t;

    // tag | index | word offset | byte alignment
    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } cache_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        EVICT_READ,
        WRITEBACK,
        FETCH
    } miss_state_e;

endpackage

//--- dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   resetn,
    input  index_t lookup_index,
    input  tag_t   lookup_tag,
    input  logic   hit_write,
    input  logic   refill_done,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    logic valid_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic dirty_q [`DCACHE_WAYS][`DCACHE_SETS];
    tag_t tag_q   [`DCACHE_WAYS][`DCACHE_SETS];

    // one bit per set names the next victim
    way_t plru_q [`DCACHE_SETS];

    logic [`DCACHE_WAYS-1:0] way_match;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_match[w] = valid_q[w][lookup_index] && (tag_q[w][lookup_index] == lookup_tag);
        end
    end

    assign hit = |way_match;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way |= way_match[w] ? way_t'(w) : way_t'(0);
        end
    end

    assign victim_way   = plru_q[lookup_index];
    assign victim_tag   = tag_q[victim_way][lookup_index];
    assign victim_dirty = valid_q[victim_way][lookup_index] && dirty_q[victim_way][lookup_index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            plru_q  <= '{default: '0};
        end else if (refill_done) begin
            // freshly fetched line is clean, next victim is the other way
            valid_q[victim_way][lookup_index] <= 1'b1;
            dirty_q[victim_way][lookup_index] <= 1'b0;
            plru_q[lookup_index]              <= ~victim_way;
        end else if (hit) begin
            plru_q[lookup_index] <= ~hit_way;
            if (hit_write) begin
                dirty_q[hit_way][lookup_index] <= 1'b1;
            end
        end
    end

    // tags only change on a refill
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[victim_way][lookup_index] <= lookup_tag;
        end
    end

endmodule

//--- dcache_data_ram.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_ram import dcache_pkg::*; (
    input  logic    clk,
    input  logic    en,
    input  way_t    way,
    input  index_t  index,
    input  offset_t offset,
    input  strobe_t strobe,
    input  word_t   wdata,
    output word_t   rdata
);

    localparam int DEPTH = `DCACHE_WAYS * `DCACHE_SETS * `DCACHE_WORDS_PER_LINE;
    localparam int ADDR_BITS = $clog2(DEPTH);

    word_t mem [DEPTH];

    logic [ADDR_BITS-1:0] addr;

    // way selects the upper half of the array
    assign addr = {way, index, offset};

    always_ff @(posedge clk) begin
        if (en) begin
            // read-first, a write returns the old word
            rdata <= mem[addr];
            for (int b = 0; b < `DCACHE_WORD_BYTES; b++) begin
                if (strobe[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- dcache_evict_buffer.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_evict_buffer import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    capture,
    input  offset_t capture_offset,
    input  word_t   capture_data,
    input  offset_t send_offset,
    output word_t   send_data
);

    // victim line copy, filled before the write burst starts
    word_t line_q [`DCACHE_WORDS_PER_LINE];

    always_ff @(posedge clk) begin
        if (resetn) begin
            line_q <= '{default: '0};
        end else if (capture) begin
            line_q[capture_offset] <= capture_data;
        end
    end

    // current write beat
    assign send_data = line_q[send_offset];

endmodule

//--- dcache_miss_fsm.sv
`timescale 1ns/1ps

module dcache_miss_fsm import dcache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        dreq_valid,
    input  logic        hit,
    input  index_t      miss_index,
    input  tag_t        miss_tag,
    input  way_t        victim_way,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    input  logic        cresp_ready,
    input  logic        cresp_last,
    output logic        idle,
    output logic        ram_en,
    output logic        ram_write,
    output way_t        ram_way,
    output offset_t     ram_offset,
    output logic        capture,
    output offset_t     capture_offset,
    output offset_t     send_offset,
    output logic        refill_done,
    output logic        creq_valid,
    output logic        creq_is_write,
    output cache_addr_t creq_addr
);

    miss_state_e state;

    // read-out offset in EVICT_READ, beat offset on the bus
    offset_t cnt;
    logic    read_done;

    way_t way_q;
    tag_t victim_tag_q;

    logic miss;
    assign miss = (state == IDLE) && dreq_valid && !hit;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= IDLE;
            cnt       <= '0;
            read_done <= 1'b0;
            capture   <= 1'b0;
        end else begin
            // read data lands one cycle after the address
            capture <= ram_en && !ram_write;
            unique case (state)
                IDLE: begin
                    if (miss) begin
                        state     <= victim_dirty ? EVICT_READ : FETCH;
                        cnt       <= '0;
                        read_done <= 1'b0;
                    end
                end
                EVICT_READ: begin
                    if (read_done) begin
                        // last word is captured on this edge
                        state <= WRITEBACK;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                        if (cnt == '1) begin
                            read_done <= 1'b1;
                        end
                    end
                end
                WRITEBACK: begin
                    if (cresp_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cresp_last) begin
                            state <= FETCH;
                            cnt   <= '0;
                        end
                    end
                end
                FETCH: begin
                    if (cresp_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cresp_last) begin
                            state <= IDLE;
                            cnt   <= '0;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // victim chosen at the miss, held for the whole sequence
    always_ff @(posedge clk) begin
        if (miss) begin
            way_q        <= victim_way;
            victim_tag_q <= victim_tag;
        end
        capture_offset <= cnt;
    end

    assign idle = (state == IDLE);

    assign ram_en     = ((state == EVICT_READ) && !read_done) || ((state == FETCH) && cresp_ready);
    assign ram_write  = (state == FETCH);
    assign ram_way    = way_q;
    assign ram_offset = cnt;

    assign send_offset = cnt;
    assign refill_done = (state == FETCH) && cresp_ready && cresp_last;

    assign creq_valid    = (state == WRITEBACK) || (state == FETCH);
    assign creq_is_write = (state == WRITEBACK);

    // line aligned, old tag for the write-back
    always_comb begin
        creq_addr       = '0;
        creq_addr.index = miss_index;
        creq_addr.tag   = (state == WRITEBACK) ? victim_tag_q : miss_tag;
    end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        dreq_valid,
    input  cache_addr_t dreq_addr,
    input  strobe_t     dreq_strobe,
    input  word_t       dreq_data,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       resp_data,
    output logic        creq_valid,
    output logic        creq_is_write,
    output cache_addr_t creq_addr,
    output word_t       creq_data,
    input  logic        cresp_ready,
    input  logic        cresp_last,
    input  word_t       cresp_data
);

    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    hit_write;
    logic    refill_done;

    logic    idle;
    logic    fsm_ram_en;
    logic    fsm_ram_write;
    way_t    fsm_ram_way;
    offset_t fsm_ram_offset;
    logic    capture;
    offset_t capture_offset;
    offset_t send_offset;

    logic    ram_en;
    way_t    ram_way;
    offset_t ram_offset;
    strobe_t ram_strobe;
    word_t   ram_wdata;
    word_t   ram_rdata;

    assign addr_ok   = idle && hit && dreq_valid;
    assign hit_write = addr_ok && (|dreq_strobe);

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
        end
    end

    // request owns the RAM when idle, the miss FSM otherwise
    assign ram_en     = idle ? addr_ok : fsm_ram_en;
    assign ram_way    = idle ? hit_way : fsm_ram_way;
    assign ram_offset = idle ? dreq_addr.offset : fsm_ram_offset;
    assign ram_strobe = idle ? dreq_strobe : {$bits(strobe_t){fsm_ram_write}};
    assign ram_wdata  = idle ? dreq_data : cresp_data;

    assign resp_data = ram_rdata;

    dcache_tag_store u_tag_store (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_index (dreq_addr.index),
        .lookup_tag   (dreq_addr.tag),
        .hit_write    (hit_write),
        .refill_done  (refill_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // held request index addresses the set during a miss too
    dcache_data_ram u_data_ram (
        .clk    (clk),
        .en     (ram_en),
        .way    (ram_way),
        .index  (dreq_addr.index),
        .offset (ram_offset),
        .strobe (ram_strobe),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    dcache_evict_buffer u_evict_buffer (
        .clk            (clk),
        .resetn         (resetn),
        .capture        (capture),
        .capture_offset (capture_offset),
        .capture_data   (ram_rdata),
        .send_offset    (send_offset),
        .send_data      (creq_data)
    );

    dcache_miss_fsm u_miss_fsm (
        .clk            (clk),
        .resetn         (resetn),
        .dreq_valid     (dreq_valid),
        .hit            (hit),
        .miss_index     (dreq_addr.index),
        .miss_tag       (dreq_addr.tag),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .cresp_ready    (cresp_ready),
        .cresp_last     (cresp_last),
        .idle           (idle),
        .ram_en         (fsm_ram_en),
        .ram_write      (fsm_ram_write),
        .ram_way        (fsm_ram_way),
        .ram_offset     (fsm_ram_offset),
        .capture        (capture),
        .capture_offset (capture_offset),
        .send_offset    (send_offset),
        .refill_done    (refill_done),
        .creq_valid     (creq_valid),
        .creq_is_write  (creq_is_write),
        .creq_addr      (creq_addr)
    );

endmodule

//--- dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions import dcache_pkg::*; (
    input logic        clk,
    input logic        resetn,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        creq_valid,
    input cache_addr_t creq_addr,
    input logic        cresp_ready,
    input logic        cresp_last
);

    // request held through the beat marked last
    req_stable: assert property (@(posedge clk) disable iff (resetn)
        (creq_valid && !(cresp_ready && cresp_last)) |=> (creq_valid && $stable(creq_addr)))
        else $error("bus request changed before the last beat");

    data_after_addr: assert property (@(posedge clk) disable iff (resetn)
        addr_ok |=> data_ok)
        else $error("data_ok missing one cycle after addr_ok");

    data_only_after_addr: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> $past(addr_ok))
        else $error("data_ok without addr_ok in the cycle before");

    // hits only while the bus is quiet
    no_hit_during_bus: assert property (@(posedge clk) disable iff (resetn)
        !(addr_ok && creq_valid))
        else $error("addr_ok high during a bus request");

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk         (clk),
    .resetn      (resetn),
    .addr_ok     (addr_ok),
    .data_ok     (data_ok),
    .creq_valid  (creq_valid),
    .creq_addr   (creq_addr),
    .cresp_ready (cresp_ready),
    .cresp_last  (cresp_last)
);

//--- tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache import dcache_pkg::*; ();

    typedef struct packed {
        logic    write;
        word_t   addr;
        strobe_t strobe;
        word_t   data;
        logic    fetch;
        logic    evict;
    } req_t;

    localparam int    N_REQ     = 15;
    localparam int    LINE      = `DCACHE_WORDS_PER_LINE;
    localparam int    TIMEOUT   = N_REQ * (2 * LINE + 16 + 40) + 16;
    localparam word_t FILL      = 32'h3c5a_96e1;
    localparam word_t LINE_MASK = ~word_t'(LINE * `DCACHE_WORD_BYTES - 1);

    // set 3 takes tags 1, 2 and 3 (A, B, C) and the last rows use the top set
    localparam req_t REQS [N_REQ] = '{
        '{1'b0, 32'h0000_20c8, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b0, 32'h0000_20d0, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b1, 32'h0000_20d0, 4'h6, 32'hdead_beef, 1'b0, 1'b0},
        '{1'b0, 32'h0000_20d0, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b1, 32'h0000_20fc, 4'hf, 32'h1234_5678, 1'b0, 1'b0},
        '{1'b0, 32'h0000_40c0, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b0, 32'h0000_20c4, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0000_60e0, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b0, 32'h0000_20fc, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
        '{1'b0, 32'h0000_40d4, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b0, 32'h0000_60e8, 4'h0, 32'h0000_0000, 1'b1, 1'b1},
        '{1'b0, 32'h0000_20d0, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b0, 32'hffff_fffc, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
        '{1'b1, 32'hffff_fffc, 4'h9, 32'ha5a5_5a5a, 1'b0, 1'b0},
        '{1'b0, 32'hffff_fffc, 4'h0, 32'h0000_0000, 1'b0, 1'b0}
    };

    logic        clk         = 1'b0;
    logic        resetn      = 1'b1;
    logic        dreq_valid  = 1'b0;
    cache_addr_t dreq_addr   = '0;
    strobe_t     dreq_strobe = '0;
    word_t       dreq_data   = '0;
    logic        cresp_ready = 1'b0;
    logic        cresp_last  = 1'b0;
    word_t       cresp_data  = '0;
    logic        addr_ok;
    logic        data_ok;
    word_t       resp_data;
    logic        creq_valid;
    logic        creq_is_write;
    cache_addr_t creq_addr;
    word_t       creq_data;

    integer seed       = 32'hb0ad_dcf1;
    int     errors     = 0;
    int     cycles     = 0;
    int     beat       = 0;
    int     fetch_cnt  = 0;
    int     evict_cnt  = 0;
    word_t  fetch_line = '0;
    word_t  beat_addr;
    logic   ready_next;
    word_t  mem [word_t];
    word_t  shadow [word_t];

    always #4 clk = ~clk;

    dcache_top u_dcache_top (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .resp_data     (resp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    function automatic word_t mem_read(word_t a);
        return mem.exists(a) ? mem[a] : (a ^ FILL);
    endfunction

    function automatic word_t shadow_read(word_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ FILL);
    endfunction

    function automatic void shadow_write(word_t a, strobe_t s, word_t d);
        word_t w;
        w = shadow_read(a);
        for (int b = 0; b < `DCACHE_WORD_BYTES; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[a] = w;
    endfunction

    // ready drops after the last beat so the bus address can switch
    always @(posedge clk) begin
        if (resetn) begin
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
            beat = 0;
        end else begin
            beat_addr = creq_addr + 4 * beat;
            if (creq_valid && cresp_ready) begin
                if (creq_is_write) begin
                    if (creq_data !== shadow_read(beat_addr)) begin
                        errors++;
                        $display("[FAIL] creq_data at %h: got %h, expected %h",
                                 beat_addr, creq_data, shadow_read(beat_addr));
                    end
                    mem[beat_addr] = creq_data;
                end else begin
                    fetch_line = creq_addr;
                end
                if (cresp_last && creq_is_write) evict_cnt++;
                if (cresp_last && !creq_is_write) fetch_cnt++;
                beat = cresp_last ? 0 : beat + 1;
            end
            ready_next = creq_valid && !(cresp_ready && cresp_last) && (($random(seed) & 3) != 0);
            cresp_ready <= ready_next;
            cresp_last  <= ready_next && (beat == LINE - 1);
            cresp_data  <= mem_read(creq_addr + 4 * beat);
        end
    end

    task automatic run_request(input req_t r);
        int    fetch_before;
        int    evict_before;
        logic  bus_seen;
        word_t expected;
        fetch_before = fetch_cnt;
        evict_before = evict_cnt;
        @(posedge clk);
        dreq_valid  <= 1'b1;
        dreq_addr   <= r.addr;
        dreq_strobe <= r.write ? r.strobe : 4'h0;
        dreq_data   <= r.data;
        // held until the lookup hits
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        bus_seen = creq_valid;
        expected = shadow_read(r.addr);
        if (r.write) shadow_write(r.addr, r.strobe, r.data);
        @(posedge clk);
        dreq_valid <= 1'b0;
        @(negedge clk);
        if (!data_ok || bus_seen || creq_valid) begin
            errors++;
            $display("no data_ok or a bus request right after addr_ok for %h", r.addr);
        end
        if (!r.write && resp_data !== expected) begin
            errors++;
            $display("[FAIL] resp_data at %h: got %h, expected %h", r.addr, resp_data, expected);
        end
        if (fetch_cnt - fetch_before != int'(r.fetch)) begin
            errors++;
            $display("[FAIL] fetch bursts: got %h, expected %h", fetch_cnt - fetch_before, r.fetch);
        end
        if (evict_cnt - evict_before != int'(r.evict)) begin
            errors++;
            $display("[FAIL] write-back bursts: got %h, expected %h",
                     evict_cnt - evict_before, r.evict);
        end
        if (r.fetch && fetch_line !== (r.addr & LINE_MASK)) begin
            errors++;
            $display("[FAIL] creq_addr: got %h, expected %h", fetch_line, r.addr & LINE_MASK);
        end
    endtask

    initial begin
        repeat (16) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        if (addr_ok || data_ok || creq_valid) begin
            errors++;
            $display("addr_ok, data_ok or creq_valid high after reset");
        end
        for (int i = 0; i < N_REQ; i++) begin
            run_request(REQS[i]);
        end
        $display("requests: %0d, errors: %0d", N_REQ, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

//--- dcache_top.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_ram.sv
dcache_evict_buffer.sv
dcache_miss_fsm.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_tag_store.sv
      - dcache_data_ram.sv
      - dcache_evict_buffer.sv
      - dcache_miss_fsm.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_assertions.sv
      - tb_dcache.sv
